// File: rv_macros.svh
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// Data path and address width.
`define XLEN 32

// Architectural registers.
`define REG_COUNT 32
`define REG_ADDR_W 5

// Data memory depth in words.
`define DMEM_WORDS 64

// First instruction address after reset.
`define RESET_PC 32'h0000_0000

`endif

// File: hw/rvIsaPkg.sv
`include "rv_macros.svh"

package rvIsaPkg;

	typedef enum logic [6:0] {
		OpLui = 7'b0110111,
		OpJal = 7'b1101111,
		OpJalr = 7'b1100111,
		OpBranch = 7'b1100011,
		OpLoad = 7'b0000011,
		OpStore = 7'b0100011,
		OpImm = 7'b0010011,
		OpReg = 7'b0110011
	} opcodeT;

	// Branch conditions.
	localparam logic [2:0] F3Beq = 3'b000;
	localparam logic [2:0] F3Bne = 3'b001;
	localparam logic [2:0] F3Blt = 3'b100;
	localparam logic [2:0] F3Bge = 3'b101;
	localparam logic [2:0] F3Bltu = 3'b110;
	localparam logic [2:0] F3Bgeu = 3'b111;

	// Load and store widths, shared by both.
	localparam logic [2:0] F3Byte = 3'b000;
	localparam logic [2:0] F3Half = 3'b001;
	localparam logic [2:0] F3Word = 3'b010;
	localparam logic [2:0] F3ByteU = 3'b100;
	localparam logic [2:0] F3HalfU = 3'b101;

	// Integer ops, for OP and OP-IMM.
	localparam logic [2:0] F3AddSub = 3'b000;
	localparam logic [2:0] F3Sll = 3'b001;
	localparam logic [2:0] F3Slt = 3'b010;
	localparam logic [2:0] F3Sltu = 3'b011;
	localparam logic [2:0] F3Xor = 3'b100;
	localparam logic [2:0] F3SrlSra = 3'b101;
	localparam logic [2:0] F3Or = 3'b110;
	localparam logic [2:0] F3And = 3'b111;

	typedef enum logic [3:0] {
		AluAdd, AluSub, AluAnd, AluOr, AluXor, AluSlt, AluSltu,
		AluSll, AluSrl, AluSra, AluEq, AluNe, AluGe, AluGeu
	} aluOpT;

	typedef struct packed {
		logic [`REG_ADDR_W-1:0] rd;
		logic [`REG_ADDR_W-1:0] rs1;
		logic [`REG_ADDR_W-1:0] rs2;
		logic [2:0] func3;
		logic func7Bit;
	} instFieldsT;

endpackage

// File: hw/rvCorePkg.sv
`include "rv_macros.svh"

package rvCorePkg;

	typedef enum logic [1:0] {
		Fetch,
		Decode,
		Execute,
		Commit
	} coreStateT;

	// IDLE is also what an unknown opcode decodes to.
	typedef enum logic [2:0] {
		IDLE,
		RegWrite,
		MemReadRegWrite,
		MemWrite,
		PCSelectWrite,
		PCWrite,
		LuiRegWrite
	} wbKindT;

	typedef struct packed {
		wbKindT wbKind;
		rvIsaPkg::aluOpT aluOp;
		logic aluSrcImm;
		logic [2:0] func3;
		logic [`REG_ADDR_W-1:0] rd;
	} ctrlWordT;

	// Retire trace, one record per instruction.
	typedef struct packed {
		logic valid;
		logic [`XLEN-1:0] pc;
		logic [`XLEN-1:0] nextPc;
		logic rdWrite;
		logic [`REG_ADDR_W-1:0] rd;
		logic [`XLEN-1:0] rdData;
	} commitT;

endpackage

// File: hw/controlUnit.sv
`timescale 1ns/1ns
`include "rv_macros.svh"

module controlUnit
	import rvIsaPkg::*;
	import rvCorePkg::*;
(
	input logic clk,
	input logic reset,
	input logic [`XLEN-1:0] instr,
	output coreStateT state,
	output ctrlWordT ctrl,
	output logic [`XLEN-1:0] imm,
	output instFieldsT fields
);
	logic [`XLEN-1:0] instrReg;
	ctrlWordT ctrlNext;
	logic [`XLEN-1:0] immNext;

	function automatic aluOpT arithOp(input logic [2:0] f3, input logic f7Bit, input logic isReg);
		case (f3)
			F3AddSub: return (isReg && f7Bit) ? AluSub : AluAdd;
			F3Sll: return AluSll;
			F3Slt: return AluSlt;
			F3Sltu: return AluSltu;
			F3Xor: return AluXor;
			F3SrlSra: return f7Bit ? AluSra : AluSrl;
			F3Or: return AluOr;
			default: return AluAnd;
		endcase
	endfunction

	function automatic aluOpT branchOp(input logic [2:0] f3);
		case (f3)
			F3Bne: return AluNe;
			F3Blt: return AluSlt;
			F3Bge: return AluGe;
			F3Bltu: return AluSltu;
			F3Bgeu: return AluGeu;
			default: return AluEq;
		endcase
	endfunction

	// Four states, wrapping from Commit back to Fetch.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= Fetch;
			ctrl <= '0;
		end
		else
		begin
			state <= coreStateT'(state + 2'd1);
			if (state == Decode)
				ctrl <= ctrlNext;
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == Fetch)
			instrReg <= instr;
		if (state == Decode)
		begin
			imm <= immNext;
			fields <= '{rd: instrReg[11:7], rs1: instrReg[19:15], rs2: instrReg[24:20],
				func3: instrReg[14:12], func7Bit: instrReg[30]};
		end
	end

	always_comb
	begin
		ctrlNext = '0;
		ctrlNext.func3 = instrReg[14:12];
		ctrlNext.rd = instrReg[11:7];
		ctrlNext.aluOp = AluAdd;
		// I format unless the opcode says otherwise.
		immNext = {{20{instrReg[31]}}, instrReg[31:20]};
		case (instrReg[6:0])
			OpLui:
			begin
				ctrlNext.wbKind = LuiRegWrite;
				immNext = {instrReg[31:12], 12'b0};
			end
			OpJal:
			begin
				ctrlNext.wbKind = PCWrite;
				immNext = {{11{instrReg[31]}}, instrReg[31], instrReg[19:12], instrReg[20],
					instrReg[30:21], 1'b0};
			end
			OpJalr:
			begin
				ctrlNext.wbKind = PCWrite;
				ctrlNext.aluSrcImm = 1'b1;
			end
			OpBranch:
			begin
				ctrlNext.wbKind = PCSelectWrite;
				ctrlNext.aluOp = branchOp(instrReg[14:12]);
				immNext = {{19{instrReg[31]}}, instrReg[31], instrReg[7], instrReg[30:25],
					instrReg[11:8], 1'b0};
			end
			OpLoad:
			begin
				ctrlNext.wbKind = MemReadRegWrite;
				ctrlNext.aluSrcImm = 1'b1;
			end
			OpStore:
			begin
				ctrlNext.wbKind = MemWrite;
				ctrlNext.aluSrcImm = 1'b1;
				immNext = {{20{instrReg[31]}}, instrReg[31:25], instrReg[11:7]};
			end
			OpImm:
			begin
				ctrlNext.wbKind = RegWrite;
				ctrlNext.aluSrcImm = 1'b1;
				ctrlNext.aluOp = arithOp(instrReg[14:12], instrReg[30], 1'b0);
			end
			OpReg:
			begin
				ctrlNext.wbKind = RegWrite;
				ctrlNext.aluOp = arithOp(instrReg[14:12], instrReg[30], 1'b1);
			end
			default: ctrlNext.wbKind = IDLE;
		endcase
	end

endmodule

// File: hw/alu.sv
`timescale 1ns/1ns
`include "rv_macros.svh"

module alu
	import rvIsaPkg::*;
(
	input aluOpT op,
	input logic [`XLEN-1:0] a,
	input logic [`XLEN-1:0] b,
	output logic [`XLEN-1:0] result
);
	localparam int ShiftW = $clog2(`XLEN);

	logic [ShiftW-1:0] shamt;

	assign shamt = b[ShiftW-1:0];

	always_comb
	begin
		case (op)
			AluAdd: result = a + b;
			AluSub: result = a - b;
			AluAnd: result = a & b;
			AluOr: result = a | b;
			AluXor: result = a ^ b;
			AluSll: result = a << shamt;
			AluSrl: result = a >> shamt;
			AluSra: result = $signed(a) >>> shamt;
			// Compares give 1 or 0, also used as the branch condition.
			AluSlt: result = `XLEN'($signed(a) < $signed(b));
			AluSltu: result = `XLEN'(a < b);
			AluEq: result = `XLEN'(a == b);
			AluNe: result = `XLEN'(a != b);
			AluGe: result = `XLEN'($signed(a) >= $signed(b));
			AluGeu: result = `XLEN'(a >= b);
			default: result = '0;
		endcase
	end

endmodule

// File: hw/regFile.sv
`timescale 1ns/1ns
`include "rv_macros.svh"

module regFile
(
	input logic clk,
	input logic reset,
	input logic [`REG_ADDR_W-1:0] readAddr1,
	input logic [`REG_ADDR_W-1:0] readAddr2,
	input logic [`REG_ADDR_W-1:0] writeAddr,
	input logic writeEnable,
	input logic [`XLEN-1:0] writeData,
	output logic [`XLEN-1:0] readData1,
	output logic [`XLEN-1:0] readData2
);
	logic [`XLEN-1:0] regs [`REG_COUNT];

	assign readData1 = regs[readAddr1];
	assign readData2 = regs[readAddr2];

	// x0 is cleared by reset and never written, so it reads as zero.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < `REG_COUNT; i++)
				regs[i] <= '0;
		end
		else if (writeEnable && writeAddr != '0)
			regs[writeAddr] <= writeData;
	end

endmodule

// File: hw/dataMem.sv
`timescale 1ns/1ns
`include "rv_macros.svh"

module dataMem
	import rvIsaPkg::*;
(
	input logic clk,
	input logic [`XLEN-1:0] addr,
	input logic [2:0] func3,
	input logic writeEnable,
	input logic [`XLEN-1:0] writeData,
	output logic [`XLEN-1:0] readData
);
	localparam int IndexW = $clog2(`DMEM_WORDS);

	logic [`XLEN-1:0] mem [`DMEM_WORDS] = '{default: '0};
	logic [IndexW-1:0] index;
	logic [`XLEN-1:0] word;
	logic [7:0] byteData;
	logic [15:0] halfData;

	// Word index wraps modulo the memory depth.
	assign index = addr[IndexW+1:2];
	assign word = mem[index];
	assign byteData = word[{addr[1:0], 3'b000} +: 8];
	assign halfData = word[{addr[1], 4'b0000} +: 16];

	always_comb
	begin
		case (func3)
			F3Byte: readData = {{24{byteData[7]}}, byteData};
			F3Half: readData = {{16{halfData[15]}}, halfData};
			F3ByteU: readData = {24'b0, byteData};
			F3HalfU: readData = {16'b0, halfData};
			default: readData = word;
		endcase
	end

	// Only the addressed lanes change.
	always_ff @(posedge clk)
	begin
		if (writeEnable)
		begin
			case (func3)
				F3Byte: mem[index][{addr[1:0], 3'b000} +: 8] <= writeData[7:0];
				F3Half: mem[index][{addr[1], 4'b0000} +: 16] <= writeData[15:0];
				default: mem[index] <= writeData;
			endcase
		end
	end

endmodule

// File: hw/writebackControl.sv
`timescale 1ns/1ns
`include "rv_macros.svh"

module writebackControl
	import rvCorePkg::*;
(
	input logic clk,
	input logic reset,
	input coreStateT state,
	input ctrlWordT ctrl,
	input logic [`XLEN-1:0] imm,
	input logic [`XLEN-1:0] aluResult,
	input logic [`XLEN-1:0] regReadData2,
	input logic [`XLEN-1:0] memReadData,
	output logic [`XLEN-1:0] memAddr,
	output logic memWriteEnable,
	output logic [`XLEN-1:0] memWriteData,
	output logic regWriteEnable,
	output logic [`XLEN-1:0] regWriteData,
	output logic pcWriteEnable,
	output logic [`XLEN-1:0] pcWriteData,
	output commitT commit
);
	// Address of the instruction in flight.
	logic [`XLEN-1:0] instrAddr;
	logic [`XLEN-1:0] linkAddr;
	logic [`XLEN-1:0] nextPc;

	assign linkAddr = instrAddr + `XLEN'(4);
	assign memAddr = aluResult;
	assign memWriteData = regReadData2;

	always_comb
	begin
		regWriteEnable = 1'b0;
		regWriteData = aluResult;
		memWriteEnable = 1'b0;
		pcWriteEnable = (state == Fetch);
		nextPc = linkAddr;
		if (state == Commit)
		begin
			case (ctrl.wbKind)
				RegWrite: regWriteEnable = 1'b1;
				MemReadRegWrite:
				begin
					regWriteEnable = 1'b1;
					regWriteData = memReadData;
				end
				MemWrite: memWriteEnable = 1'b1;
				PCSelectWrite:
				begin
					pcWriteEnable = (aluResult != '0);
					if (pcWriteEnable)
						nextPc = instrAddr + imm;
				end
				PCWrite:
				begin
					// JAL leaves the ALU unused; aluSrcImm marks JALR.
					pcWriteEnable = 1'b1;
					nextPc = ctrl.aluSrcImm ? {aluResult[`XLEN-1:1], 1'b0} : instrAddr + imm;
					regWriteEnable = 1'b1;
					regWriteData = linkAddr;
				end
				LuiRegWrite:
				begin
					regWriteEnable = 1'b1;
					regWriteData = imm;
				end
				default: ;
			endcase
		end
		pcWriteData = nextPc;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			instrAddr <= `RESET_PC;
		else if (state == Commit)
			instrAddr <= nextPc;
	end

	always_comb
	begin
		commit.valid = (state == Commit);
		commit.pc = instrAddr;
		commit.nextPc = nextPc;
		commit.rdWrite = regWriteEnable;
		commit.rd = ctrl.rd;
		commit.rdData = regWriteData;
	end

endmodule

// File: hw/rvCore.sv
`timescale 1ns/1ns
`include "rv_macros.svh"

module rvCore
	import rvIsaPkg::*;
	import rvCorePkg::*;
(
	input logic clk,
	input logic reset,
	output logic [`XLEN-1:0] instrAddr,
	input logic [`XLEN-1:0] instr,
	output commitT commit
);
	coreStateT state;
	ctrlWordT ctrl;
	instFieldsT fields;
	logic [`XLEN-1:0] imm;
	logic [`XLEN-1:0] pc;
	logic [`XLEN-1:0] readData1;
	logic [`XLEN-1:0] readData2;
	logic [`XLEN-1:0] aluB;
	logic [`XLEN-1:0] aluResult;
	logic [`XLEN-1:0] memAddr;
	logic [`XLEN-1:0] memWriteData;
	logic [`XLEN-1:0] memReadData;
	logic [`XLEN-1:0] regWriteData;
	logic [`XLEN-1:0] pcWriteData;
	logic memWriteEnable;
	logic regWriteEnable;
	logic pcWriteEnable;

	always_ff @(posedge clk)
	begin
		if (reset)
			pc <= `RESET_PC;
		else if (pcWriteEnable)
			pc <= pcWriteData;
	end

	assign instrAddr = pc;
	assign aluB = ctrl.aluSrcImm ? imm : readData2;

	controlUnit control (.clk, .reset, .instr, .state, .ctrl, .imm, .fields);

	alu alu (.op(ctrl.aluOp), .a(readData1), .b(aluB), .result(aluResult));

	regFile regs (.clk, .reset, .readAddr1(fields.rs1), .readAddr2(fields.rs2),
		.writeAddr(ctrl.rd), .writeEnable(regWriteEnable), .writeData(regWriteData),
		.readData1, .readData2);

	dataMem dmem (.clk, .addr(memAddr), .func3(ctrl.func3), .writeEnable(memWriteEnable),
		.writeData(memWriteData), .readData(memReadData));

	writebackControl writeback (.clk, .reset, .state, .ctrl, .imm, .aluResult,
		.regReadData2(readData2), .memReadData, .memAddr, .memWriteEnable, .memWriteData,
		.regWriteEnable, .regWriteData, .pcWriteEnable, .pcWriteData, .commit);

endmodule

// File: verif/rvCore_asserts.sv
`timescale 1ns/1ns

module rvCore_asserts
	import rvCorePkg::*;
(
	input logic clk,
	input logic reset,
	input coreStateT state,
	input logic regWriteEnable,
	input logic memWriteEnable,
	input logic pcWriteEnable,
	input logic commitValid
);
	int failCount = 0;

	// Architectural writes happen in Commit only.
	writesInCommit: assert property (@(posedge clk) disable iff (reset)
		(regWriteEnable || memWriteEnable) |-> state == Commit)
	else
	begin
		failCount++;
		$error("Register or memory write outside Commit.");
	end

	oneWriteKind: assert property (@(posedge clk) disable iff (reset)
		!(regWriteEnable && memWriteEnable))
	else
	begin
		failCount++;
		$error("Register and memory written in the same cycle.");
	end

	// Fetch always advances the PC.
	pcInFetch: assert property (@(posedge clk) disable iff (reset)
		state == Fetch |-> pcWriteEnable)
	else
	begin
		failCount++;
		$error("PC not written in Fetch.");
	end

	singleCommit: assert property (@(posedge clk) disable iff (reset)
		commitValid |=> !commitValid)
	else
	begin
		failCount++;
		$error("Commit valid held for two cycles.");
	end

endmodule

bind writebackControl rvCore_asserts asserts (.clk, .reset, .state, .regWriteEnable,
	.memWriteEnable, .pcWriteEnable, .commitValid(commit.valid));

// File: verif/rvCoreTb.sv
`timescale 1ns/1ns
`include "rv_macros.svh"

module rvCoreTb
	import rvIsaPkg::*;
	import rvCorePkg::*;
();
	localparam int Programs = 8;
	localparam int RandomLen = 48;
	localparam int SelfIdx = RandomLen + `REG_COUNT;
	localparam int ResetCycles = 4;
	localparam int TimeoutCycles = Programs * (RandomLen + 32) * 4 + 200;
	localparam int MemBytes = `DMEM_WORDS * 4;

	// Slot kinds. A JALR takes two slots, its target setup and the jump.
	localparam int KindOp = 0;
	localparam int KindImm = 1;
	localparam int KindLui = 2;
	localparam int KindLoad = 3;
	localparam int KindStore = 4;
	localparam int KindBranch = 5;
	localparam int KindJal = 6;
	localparam int KindJalrSetup = 7;
	localparam int KindJalrJump = 8;

	logic clk = 1'b0;
	logic reset;
	logic [`XLEN-1:0] instrAddr;
	logic [`XLEN-1:0] instr;
	commitT commit;
	commitT expected;
	logic [`XLEN-1:0] prog [128];
	logic [`XLEN-1:0] modelRegs [`REG_COUNT];
	logic [7:0] modelMem [MemBytes];
	logic [`XLEN-1:0] modelPc;
	int kind [RandomLen];
	int seed = 88;
	int cycles = 0;
	int sinceCommit = 0;
	int errors = 0;
	logic running;
	logic done;

	rvCore uut (.clk, .reset, .instrAddr, .instr, .commit);

	assign instr = prog[instrAddr[8:2]];

	always #4 clk = ~clk;

	task automatic stopWithFailure(input string line);
		errors++;
		$display("%s", line);
		$display("test failed");
		$fatal(1);
	endtask

	function automatic int randBelow(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic logic [31:0] rType(input logic alt, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OpReg};
	endfunction

	function automatic logic [31:0] iType(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] sType(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [2:0] f3);
		return {imm[11:5], rs2, 5'd0, f3, imm[4:0], OpStore};
	endfunction

	function automatic logic [31:0] bType(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OpBranch};
	endfunction

	function automatic logic [31:0] jType(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OpJal};
	endfunction

	// Never lands between a JALR and its setup.
	function automatic int forwardTarget(input int from);
		int t;
		t = from + 1 + randBelow(RandomLen - from);
		if (t < RandomLen && kind[t] == KindJalrJump)
			t--;
		return t;
	endfunction

	task automatic buildProgram();
		int i;
		int k;
		int t;
		int width;
		logic [2:0] f3;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [4:0] link;
		logic [11:0] imm;
		i = 0;
		while (i < RandomLen)
		begin
			k = randBelow(8);
			if (k == KindJalrSetup && i < RandomLen - 1)
			begin
				kind[i] = KindJalrSetup;
				kind[i + 1] = KindJalrJump;
				i += 2;
			end
			else
			begin
				kind[i] = (k == KindJalrSetup) ? KindOp : k;
				i++;
			end
		end
		for (int n = 0; n < RandomLen; n++)
		begin
			rd = 5'(randBelow(32));
			rs1 = 5'(randBelow(32));
			rs2 = 5'(randBelow(32));
			f3 = 3'(randBelow(8));
			imm = 12'(randBelow(4096));
			case (kind[n])
				KindOp: prog[n] = rType((f3 == 0 || f3 == 5) && imm[0], rs2, rs1, f3, rd);
				KindImm:
				begin
					if (f3 == F3Sll)
						imm = {7'b0, imm[4:0]};
					else if (f3 == F3SrlSra)
						imm = {1'b0, imm[10], 5'b0, imm[4:0]};
					prog[n] = iType(imm, rs1, f3, rd, OpImm);
				end
				KindLui: prog[n] = {$random(seed)} & 32'hffff_f000 | {20'b0, rd, OpLui};
				KindLoad, KindStore:
				begin
					f3 = (kind[n] == KindLoad) ? 3'(randBelow(5)) : 3'(randBelow(3));
					if (f3 >= 3)
						f3 = f3 + 3'd1;
					width = 1 << f3[1:0];
					imm = 12'(randBelow(MemBytes / width) * width);
					if (kind[n] == KindLoad)
						prog[n] = iType(imm, 5'd0, f3, rd, OpLoad);
					else
						prog[n] = sType(imm, rs2, f3);
				end
				KindBranch:
				begin
					f3 = 3'(randBelow(6));
					if (f3 >= 2)
						f3 = f3 + 3'd2;
					t = forwardTarget(n);
					prog[n] = bType(13'((t - n) * 4), rs2, rs1, f3);
				end
				KindJal: prog[n] = jType(21'((forwardTarget(n) - n) * 4), rd);
				KindJalrSetup:
				begin
					// Odd offset so the jump has to clear bit 0.
					link = 5'(1 + randBelow(31));
					t = forwardTarget(n + 1);
					prog[n] = iType(12'(t * 4), 5'd0, 3'd0, link, OpImm);
					prog[n + 1] = iType(12'd1, link, 3'd0, rd, OpJalr);
				end
				default: ;
			endcase
		end
		// Read back every register through x0, then spin.
		for (int r = 0; r < `REG_COUNT; r++)
			prog[RandomLen + r] = iType(12'd0, 5'(r), 3'd0, 5'd0, OpImm);
		prog[SelfIdx] = jType(21'd0, 5'd0);
	endtask

	function automatic logic [31:0] arith(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return {31'b0, $signed(a) < $signed(b)};
			3'd3: return {31'b0, a < b};
			3'd4: return a ^ b;
			3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic [31:0] loadModel(input logic [7:0] base, input logic [2:0] f3);
		logic [31:0] w;
		w = {modelMem[base + 8'd3], modelMem[base + 8'd2], modelMem[base + 8'd1],
			modelMem[base]};
		case (f3)
			F3Byte: return {{24{w[7]}}, w[7:0]};
			F3Half: return {{16{w[15]}}, w[15:0]};
			F3ByteU: return {24'b0, w[7:0]};
			F3HalfU: return {16'b0, w[15:0]};
			default: return w;
		endcase
	endfunction

	task automatic storeModel(input logic [7:0] base, input logic [2:0] f3,
		input logic [31:0] data);
		modelMem[base] = data[7:0];
		if (f3 != F3Byte)
			modelMem[base + 8'd1] = data[15:8];
		if (f3 == F3Word)
		begin
			modelMem[base + 8'd2] = data[23:16];
			modelMem[base + 8'd3] = data[31:24];
		end
	endtask

	// Reference ISA step, straight from the instruction bits.
	task automatic executeModel(output commitT exp);
		logic [31:0] ins;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] immI;
		logic [31:0] immS;
		logic [31:0] immB;
		logic [31:0] immJ;
		logic [2:0] f3;
		logic take;
		ins = prog[modelPc[8:2]];
		f3 = ins[14:12];
		a = modelRegs[ins[19:15]];
		b = modelRegs[ins[24:20]];
		immI = {{20{ins[31]}}, ins[31:20]};
		immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
		immB = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
		immJ = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
		exp = '0;
		exp.valid = 1'b1;
		exp.pc = modelPc;
		exp.nextPc = modelPc + 32'd4;
		exp.rd = ins[11:7];
		exp.rdWrite = 1'b1;
		case (ins[6:0])
			OpLui: exp.rdData = {ins[31:12], 12'b0};
			OpJal:
			begin
				exp.rdData = modelPc + 32'd4;
				exp.nextPc = modelPc + immJ;
			end
			OpJalr:
			begin
				exp.rdData = modelPc + 32'd4;
				exp.nextPc = (a + immI) & ~32'd1;
			end
			OpBranch:
			begin
				case (f3)
					F3Beq: take = (a == b);
					F3Bne: take = (a != b);
					F3Blt: take = ($signed(a) < $signed(b));
					F3Bge: take = ($signed(a) >= $signed(b));
					F3Bltu: take = (a < b);
					default: take = (a >= b);
				endcase
				exp.rdWrite = 1'b0;
				if (take)
					exp.nextPc = modelPc + immB;
			end
			OpLoad: exp.rdData = loadModel(8'(a + immI), f3);
			OpStore:
			begin
				exp.rdWrite = 1'b0;
				storeModel(8'(a + immS), f3, b);
			end
			OpImm: exp.rdData = arith(f3, f3 == F3SrlSra && ins[30], a, immI);
			OpReg: exp.rdData = arith(f3, ins[30], a, b);
			default: exp.rdWrite = 1'b0;
		endcase
		if (exp.rdWrite && exp.rd != 0)
			modelRegs[exp.rd] = exp.rdData;
		modelPc = exp.nextPc;
	endtask

	task automatic checkFetchAddr(input logic [`XLEN-1:0] got);
		if (got !== modelPc)
			stopWithFailure($sformatf("[FAIL] %0t: fetch from %h, expected %h",
				$time, got, modelPc));
	endtask

	task automatic checkCommit(input commitT got, input commitT exp);
		if (got.pc !== exp.pc || got.nextPc !== exp.nextPc || got.rdWrite !== exp.rdWrite)
			stopWithFailure($sformatf("[FAIL] %0t: pc %h nextPc %h rdWrite %b, expected %h %h %b",
				$time, got.pc, got.nextPc, got.rdWrite, exp.pc, exp.nextPc, exp.rdWrite));
		if (exp.rdWrite && (got.rd !== exp.rd || got.rdData !== exp.rdData))
			stopWithFailure($sformatf("[FAIL] %0t: pc %h writes x%0d = %h, expected x%0d = %h",
				$time, got.pc, got.rd, got.rdData, exp.rd, exp.rdData));
	endtask

	task automatic checkRegs(input int r, input logic [`XLEN-1:0] got);
		if (got !== modelRegs[r])
			stopWithFailure($sformatf("[FAIL] %0t: x%0d reads %h, expected %h",
				$time, r, got, modelRegs[r]));
	endtask

	always @(negedge clk)
	begin
		if (running && !done)
		begin
			sinceCommit++;
			// First cycle after a commit is Fetch.
			if (sinceCommit == 1)
				checkFetchAddr(instrAddr);
			if (commit.valid)
			begin
				if (sinceCommit != 4)
					stopWithFailure($sformatf("[FAIL] %0t: commit came %0d cycles after the last",
						$time, sinceCommit));
				if (modelPc >= RandomLen * 4 && modelPc < SelfIdx * 4)
					checkRegs(int'(modelPc >> 2) - RandomLen, commit.rdData);
				executeModel(expected);
				checkCommit(commit, expected);
				if (expected.pc == SelfIdx * 4)
					done = 1'b1;
				sinceCommit = 0;
			end
			else if (sinceCommit >= 4)
				stopWithFailure($sformatf("[FAIL] %0t: no commit within 4 cycles", $time));
		end
	end

	always @(negedge clk)
	begin
		if (uut.writeback.asserts.failCount != 0)
			stopWithFailure("An assertion on the writeback controller failed.");
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= TimeoutCycles)
			stopWithFailure("Timeout: the core did not finish all programs in time.");
	end

	initial
	begin
		reset = 1'b1;
		running = 1'b0;
		done = 1'b0;
		for (int i = 0; i < MemBytes; i++)
			modelMem[i] = 8'h00;
		for (int p = 0; p < Programs; p++)
		begin
			running = 1'b0;
			buildProgram();
			@(posedge clk);
			reset <= 1'b1;
			repeat (ResetCycles) @(posedge clk);
			reset <= 1'b0;
			modelPc = `RESET_PC;
			for (int r = 0; r < `REG_COUNT; r++)
				modelRegs[r] = '0;
			sinceCommit = 0;
			done = 1'b0;
			running = 1'b1;
			wait (done);
		end
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

// File: files.f
+incdir+.
hw/rvIsaPkg.sv
hw/rvCorePkg.sv
hw/controlUnit.sv
hw/alu.sv
hw/regFile.sv
hw/dataMem.sv
hw/writebackControl.sv
hw/rvCore.sv
verif/rvCore_asserts.sv
verif/rvCoreTb.sv

// File: Bender.yml
package:
  name: rv_core

export_include_dirs:
  - .

sources:
  - files:
      - hw/rvIsaPkg.sv
      - hw/rvCorePkg.sv
      - hw/controlUnit.sv
      - hw/alu.sv
      - hw/regFile.sv
      - hw/dataMem.sv
      - hw/writebackControl.sv
      - hw/rvCore.sv
  - target: simulation
    files:
      - verif/rvCore_asserts.sv
      - verif/rvCoreTb.sv
